//--- hdl/loadPkg.sv
`default_nettype none

package loadPkg;

    localparam int RAM_ADDR_BITS = 10; // word index comes from address bits 11 to 2.
    localparam int RAM_WORDS = 1 << RAM_ADDR_BITS;
    localparam int WORD_BYTE_BITS = 2;
    localparam logic [7:0] CREG_PAGE = 8'hFF; // top address byte of the control registers.

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [11:0] imm_t;
    typedef logic [6:0] sqN_t;
    typedef logic [5:0] tag_t;
    typedef logic [31:0] pc_t;
    typedef logic [1:0] size_t;
    typedef logic [RAM_ADDR_BITS-1:0] ramIdx_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // register forms and the swap stay at the end so range compares decode them.
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        LB_RR,
        LH_RR,
        LW_RR,
        LBU_RR,
        LHU_RR,
        AMOSWAP_W
    } loadOp_t;

    // true when sqN is younger than refSqN under wrapping sequence numbers.
    function automatic logic isYounger(sqN_t sqN, sqN_t refSqN);
        logic signed [$bits(sqN_t)-1:0] diff;
        diff = sqN - refSqN;
        return diff > 0;
    endfunction

endpackage

`default_nettype wire

//--- hdl/loadAgu.sv
`default_nettype none
`timescale 1ns/100ps

module loadAgu (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   en,
    input  wire                   stall,
    input  wire                   inValid,
    input  wire loadPkg::loadOp_t inOp,
    input  wire loadPkg::addr_t   inSrcA,
    input  wire loadPkg::addr_t   inSrcB,
    input  wire loadPkg::imm_t    inImm,
    input  wire loadPkg::pc_t     inPc,
    input  wire loadPkg::tag_t    inTagDst,
    input  wire loadPkg::sqN_t    inSqN,
    input  wire                   modeNoCregsRd,
    input  wire                   modeRmask,
    input  wire [63:0]            rmask,
    input  wire                   branchTaken,
    input  wire loadPkg::sqN_t    branchSqN,
    output logic                  aguValid,
    output loadPkg::addr_t        aguAddr,
    output loadPkg::pc_t          aguPc,
    output loadPkg::tag_t         aguTagDst,
    output loadPkg::sqN_t         aguSqN,
    output logic                  aguException,
    output logic                  aguDoNotCommit,
    output loadPkg::size_t        aguSize,
    output logic [1:0]            aguShamt,
    output logic                  aguSignExtend
);
    import loadPkg::*;

    addr_t      addr;
    logic       isRegForm;
    logic       accept;
    logic       exception;
    size_t      size;
    logic [1:0] shamt;
    logic       signExtend;

    assign isRegForm = inOp >= LB_RR;
    assign addr = inSrcA + (isRegForm ? inSrcB : {{20{inImm[11]}}, inImm});
    assign accept = en && !stall && inValid && !(branchTaken && isYounger(inSqN, branchSqN));

    always_comb begin
        size = SIZE_WORD; // words and the swap load a plain word.
        signExtend = 1'b0;
        case (inOp)
            LB, LB_RR: begin
                size = SIZE_BYTE;
                signExtend = 1'b1;
            end
            LBU, LBU_RR: begin
                size = SIZE_BYTE;
            end
            LH, LH_RR: begin
                size = SIZE_HALF;
                signExtend = 1'b1;
            end
            LHU, LHU_RR: begin
                size = SIZE_HALF;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (size)
            SIZE_BYTE: shamt = addr[1:0];
            SIZE_HALF: shamt = {addr[1], 1'b0};
            default: shamt = 2'b00;
        endcase
    end

    always_comb begin
        exception = addr == '0;
        if (size == SIZE_HALF && addr[0]) begin
            exception = 1'b1;
        end
        if (size == SIZE_WORD && addr[1:0] != 2'b00) begin
            exception = 1'b1;
        end
        if (modeNoCregsRd && addr[31:24] == CREG_PAGE) begin
            exception = 1'b1;
        end
        if (modeRmask && !rmask[addr[31:26]]) begin
            exception = 1'b1; // each rmask bit covers a 64 MiB region.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aguValid <= 1'b0;
        end else if (accept) begin
            aguValid <= 1'b1;
        end else if (!stall || (aguValid && branchTaken && isYounger(aguSqN, branchSqN))) begin
            aguValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aguAddr <= addr;
            aguPc <= inPc;
            aguTagDst <= inTagDst;
            aguSqN <= inSqN;
            aguException <= exception;
            aguDoNotCommit <= inOp >= AMOSWAP_W; // the swap may not commit as a plain load.
            aguSize <= size;
            aguShamt <= shamt;
            aguSignExtend <= signExtend;
        end
    end

endmodule

`default_nettype wire

//--- hdl/loadDataRam.sv
`default_nettype none
`timescale 1ns/100ps

module loadDataRam (
    input  wire                 clk,
    input  wire                 rdEn,
    input  wire loadPkg::addr_t rdAddr,
    input  wire                 wrEn,
    input  wire loadPkg::addr_t wrAddr,
    input  wire loadPkg::word_t wrData,
    output loadPkg::word_t      rdData
);
    import loadPkg::*;

    word_t   mem [RAM_WORDS];
    ramIdx_t rdIdx;
    ramIdx_t wrIdx;

    // byte offset bits are dropped since the memory is word wide.
    assign rdIdx = rdAddr[RAM_ADDR_BITS+WORD_BYTE_BITS-1:WORD_BYTE_BITS];
    assign wrIdx = wrAddr[RAM_ADDR_BITS+WORD_BYTE_BITS-1:WORD_BYTE_BITS];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdIdx]; // a read under a same-address write returns the old word.
        end
    end

endmodule

`default_nettype wire

//--- hdl/loadAligner.sv
`default_nettype none
`timescale 1ns/100ps

module loadAligner (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  wire                 branchTaken,
    input  wire loadPkg::sqN_t  branchSqN,
    input  wire                 aguValid,
    input  wire loadPkg::pc_t   aguPc,
    input  wire loadPkg::tag_t  aguTagDst,
    input  wire loadPkg::sqN_t  aguSqN,
    input  wire                 aguException,
    input  wire                 aguDoNotCommit,
    input  wire loadPkg::size_t aguSize,
    input  wire [1:0]           aguShamt,
    input  wire                 aguSignExtend,
    input  wire loadPkg::word_t ramData,
    output logic                resultValid,
    output loadPkg::word_t      resultData,
    output loadPkg::tag_t       resultTagDst,
    output loadPkg::sqN_t       resultSqN,
    output loadPkg::pc_t        resultPc,
    output logic                resultException,
    output logic                resultDoNotCommit
);
    import loadPkg::*;

    size_t      size;
    logic [1:0] shamt;
    logic       signExtend;
    word_t      shifted;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else if (!stall) begin
            resultValid <= aguValid && !(branchTaken && isYounger(aguSqN, branchSqN));
        end else if (branchTaken && isYounger(resultSqN, branchSqN)) begin
            resultValid <= 1'b0;
        end
    end

    // captured together with the memory read so both stay in step under stall.
    always_ff @(posedge clk) begin
        if (!stall) begin
            resultPc <= aguPc;
            resultTagDst <= aguTagDst;
            resultSqN <= aguSqN;
            resultException <= aguException;
            resultDoNotCommit <= aguDoNotCommit;
            size <= aguSize;
            shamt <= aguShamt;
            signExtend <= aguSignExtend;
        end
    end

    assign shifted = ramData >> {shamt, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: resultData = {{24{signExtend && shifted[7]}}, shifted[7:0]};
            SIZE_HALF: resultData = {{16{signExtend && shifted[15]}}, shifted[15:0]};
            default: resultData = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/loadUnit.sv
`default_nettype none
`timescale 1ns/100ps

module loadUnit (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   en,
    input  wire                   stall,
    input  wire                   inValid,
    input  wire loadPkg::loadOp_t inOp,
    input  wire loadPkg::addr_t   inSrcA,
    input  wire loadPkg::addr_t   inSrcB,
    input  wire loadPkg::imm_t    inImm,
    input  wire loadPkg::pc_t     inPc,
    input  wire loadPkg::tag_t    inTagDst,
    input  wire loadPkg::sqN_t    inSqN,
    input  wire                   modeNoCregsRd,
    input  wire                   modeRmask,
    input  wire [63:0]            rmask,
    input  wire                   branchTaken,
    input  wire loadPkg::sqN_t    branchSqN,
    input  wire                   ramWrEn,
    input  wire loadPkg::addr_t   ramWrAddr,
    input  wire loadPkg::word_t   ramWrData,
    output logic                  resultValid,
    output loadPkg::word_t        resultData,
    output loadPkg::tag_t         resultTagDst,
    output loadPkg::sqN_t         resultSqN,
    output loadPkg::pc_t          resultPc,
    output logic                  resultException,
    output logic                  resultDoNotCommit
);
    import loadPkg::*;

    logic       aguValid;
    addr_t      aguAddr;
    pc_t        aguPc;
    tag_t       aguTagDst;
    sqN_t       aguSqN;
    logic       aguException;
    logic       aguDoNotCommit;
    size_t      aguSize;
    logic [1:0] aguShamt;
    logic       aguSignExtend;
    word_t      ramData;

    loadAgu loadAgu_inst (
        .clk(clk),
        .rst(rst),
        .en(en),
        .stall(stall),
        .inValid(inValid),
        .inOp(inOp),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inImm(inImm),
        .inPc(inPc),
        .inTagDst(inTagDst),
        .inSqN(inSqN),
        .modeNoCregsRd(modeNoCregsRd),
        .modeRmask(modeRmask),
        .rmask(rmask),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .aguValid(aguValid),
        .aguAddr(aguAddr),
        .aguPc(aguPc),
        .aguTagDst(aguTagDst),
        .aguSqN(aguSqN),
        .aguException(aguException),
        .aguDoNotCommit(aguDoNotCommit),
        .aguSize(aguSize),
        .aguShamt(aguShamt),
        .aguSignExtend(aguSignExtend)
    );

    loadDataRam loadDataRam_inst (
        .clk(clk),
        .rdEn(!stall), // the memory holds its output word while the pipeline is frozen.
        .rdAddr(aguAddr),
        .wrEn(ramWrEn),
        .wrAddr(ramWrAddr),
        .wrData(ramWrData),
        .rdData(ramData)
    );

    loadAligner loadAligner_inst (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .aguValid(aguValid),
        .aguPc(aguPc),
        .aguTagDst(aguTagDst),
        .aguSqN(aguSqN),
        .aguException(aguException),
        .aguDoNotCommit(aguDoNotCommit),
        .aguSize(aguSize),
        .aguShamt(aguShamt),
        .aguSignExtend(aguSignExtend),
        .ramData(ramData),
        .resultValid(resultValid),
        .resultData(resultData),
        .resultTagDst(resultTagDst),
        .resultSqN(resultSqN),
        .resultPc(resultPc),
        .resultException(resultException),
        .resultDoNotCommit(resultDoNotCommit)
    );

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`default_nettype none
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20; // 40 ns clock period.
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0; // released on a falling edge like all other stimulus.
    end

endmodule

`default_nettype wire

//--- sim/loadUnit_props.sv
`default_nettype none
`timescale 1ns/100ps

module loadUnit_props (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire branchTaken,
    input wire aguValid,
    input wire resultValid
);

    resultIdleAfterReset: assert property (@(posedge clk) rst |=> !resultValid)
        else $error("resultValid was high in the cycle after reset.");

    // a frozen pipeline keeps its uop unless a branch overtakes it.
    aguHeldUnderStall: assert property (@(posedge clk) disable iff (rst)
        aguValid && stall && !branchTaken |=> aguValid)
        else $error("aguValid dropped while the pipeline was stalled.");

    aguFeedsResult: assert property (@(posedge clk) disable iff (rst)
        !stall && !branchTaken |=> resultValid == $past(aguValid))
        else $error("resultValid did not follow aguValid of the previous cycle.");

endmodule

bind loadUnit loadUnit_props loadUnit_props_inst (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .branchTaken(branchTaken),
    .aguValid(aguValid),
    .resultValid(resultValid)
);

`default_nettype wire

//--- sim/loadUnitTb.sv
`default_nettype none
`timescale 1ns/100ps

module loadUnitTb;
    import loadPkg::*;

    localparam int N_ALIGNED = 60;
    localparam int N_FAULT = 30;
    localparam int N_MODE = 20;
    localparam int N_STALL = 80;
    localparam int N_BRANCH = 8;
    localparam int TOTAL_UOPS = N_ALIGNED + N_FAULT + 2 + 2 * N_MODE + N_STALL + 4 * N_BRANCH;
    localparam int TIMEOUT_CYCLES = TOTAL_UOPS * 4 + 200;

    typedef struct {
        sqN_t sqN;
        tag_t tag;
        pc_t pc;
        logic exc;
        logic dnc;
        word_t data;
        int cycle;
        int stalls;
    } expect_t;

    logic clk;
    logic rst;
    logic en;
    logic stall;
    logic inValid;
    loadOp_t inOp;
    addr_t inSrcA;
    addr_t inSrcB;
    imm_t inImm;
    pc_t inPc;
    tag_t inTagDst;
    sqN_t inSqN;
    logic modeNoCregsRd;
    logic modeRmask;
    logic [63:0] rmask;
    logic branchTaken;
    sqN_t branchSqN;
    logic ramWrEn;
    addr_t ramWrAddr;
    word_t ramWrData;
    logic resultValid;
    word_t resultData;
    tag_t resultTagDst;
    sqN_t resultSqN;
    pc_t resultPc;
    logic resultException;
    logic resultDoNotCommit;

    word_t memCopy [RAM_WORDS];
    expect_t expQ[$];
    sqN_t nextSqN = '0;
    logic running = 1'b0;
    int cycle = 0;
    int stallCount = 0;
    int cycleCount = 0;
    int errors = 0;
    int delivered = 0;
    int errAtStart = 0;
    int doneAtStart = 0;

    clockGen clockGen_inst (
        .clk(clk),
        .rst(rst)
    );

    loadUnit loadUnit_inst (.*);

    function automatic logic younger(sqN_t s, sqN_t r);
        sqN_t d;
        d = s - r;
        return d != '0 && !d[6]; // a positive wrapped difference means younger.
    endfunction

    function automatic int opBytes(loadOp_t op);
        case (op)
            LB, LBU, LB_RR, LBU_RR: return 1;
            LH, LHU, LH_RR, LHU_RR: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic loadOp_t randomOp();
        return loadOp_t'(4'($urandom_range(9)));
    endfunction

    function automatic addr_t alignedAddr(loadOp_t op);
        addr_t a;
        a = $urandom() & ~addr_t'(opBytes(op) - 1);
        if (a == '0) begin
            a = 32'h0000_0040;
        end
        return a;
    endfunction

    // returns the exception, the doNotCommit flag and the loaded data.
    function automatic logic [33:0] refLoad(loadOp_t op, addr_t a, addr_t b, imm_t imm,
                                            logic noCregs, logic useRmask, logic [63:0] mask);
        addr_t addr;
        int bytes;
        logic exc;
        word_t w;
        addr = a + ((op >= LB_RR) ? b : addr_t'($signed(imm)));
        bytes = opBytes(op);
        exc = addr == '0 || (addr & addr_t'(bytes - 1)) != '0;
        exc = exc || (noCregs && addr[31:24] == 8'hFF) || (useRmask && !mask[addr[31:26]]);
        w = memCopy[addr[11:2]] >> (addr[1:0] * 8);
        if (bytes == 1) begin
            w = (op == LB || op == LB_RR) ? word_t'($signed(w[7:0])) : word_t'(w[7:0]);
        end else if (bytes == 2) begin
            w = (op == LH || op == LH_RR) ? word_t'($signed(w[15:0])) : word_t'(w[15:0]);
        end
        return {exc, op == AMOSWAP_W, w};
    endfunction

    task automatic checkField(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compareResult();
        expect_t e;
        assert (expQ.size() != 0) else begin
            $display("a result with sqN %0d came out at %0t with no load outstanding",
                     resultSqN, $time);
            errors++;
        end
        if (expQ.size() != 0) begin
            e = expQ.pop_front();
            checkField("resultSqN", 32'(resultSqN), 32'(e.sqN));
            checkField("resultTagDst", 32'(resultTagDst), 32'(e.tag));
            checkField("resultPc", resultPc, e.pc);
            checkField("resultException", 32'(resultException), 32'(e.exc));
            checkField("resultDoNotCommit", 32'(resultDoNotCommit), 32'(e.dnc));
            if (!e.exc) begin
                checkField("resultData", resultData, e.data);
            end
            checkField("latency", 32'(cycle - e.cycle - (stallCount - e.stalls)), 32'd2);
            delivered++;
        end
    endtask

    task automatic pushExpected();
        expect_t e;
        logic [33:0] r;
        r = refLoad(inOp, inSrcA, inSrcB, inImm, modeNoCregsRd, modeRmask, rmask);
        e.sqN = inSqN;
        e.tag = inTagDst;
        e.pc = inPc;
        e.exc = r[33];
        e.dnc = r[32];
        e.data = r[31:0];
        e.cycle = cycle;
        e.stalls = stallCount;
        expQ.push_back(e);
    endtask

    // model of both stages, sampled where the registered outputs are stable.
    always @(posedge clk) begin
        if (!rst) begin
            if (resultValid && !stall) begin
                compareResult();
            end
            if (branchTaken) begin
                for (int i = expQ.size() - 1; i >= 0; i--) begin
                    if (younger(expQ[i].sqN, branchSqN)) begin
                        expQ.delete(i);
                    end
                end
            end
            if (en && !stall && inValid && !(branchTaken && younger(inSqN, branchSqN))) begin
                pushExpected();
            end
            if (stall) begin
                stallCount++;
            end
            cycle++;
        end
    end

    // the uop stays on the inputs until a cycle without stall takes it.
    task automatic issue(loadOp_t op, addr_t addr, int stallPct);
        imm_t imm;
        addr_t other;
        imm = imm_t'($urandom());
        other = $urandom();
        en = 1'b1;
        inValid = 1'b1;
        inOp = op;
        inImm = imm;
        inSrcB = other;
        inSrcA = addr - ((op >= LB_RR) ? other : addr_t'($signed(imm)));
        inPc = $urandom();
        inTagDst = tag_t'($urandom());
        inSqN = nextSqN;
        do begin
            stall = int'($urandom_range(99)) < stallPct;
            @(negedge clk);
        end while (stall);
        nextSqN++;
    endtask

    task automatic idle(int n);
        en = 1'b1;
        inValid = 1'b0;
        stall = 1'b0;
        branchTaken = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic branchRound(int keep, logic holdStall);
        sqN_t first;
        loadOp_t op;
        first = nextSqN;
        repeat (4) begin
            op = randomOp();
            issue(op, alignedAddr(op), 0);
        end
        branchTaken = 1'b1;
        branchSqN = first + sqN_t'(keep);
        stall = holdStall;
        inSqN = nextSqN; // a younger uop at the input must be refused.
        inValid = 1'b1;
        @(negedge clk);
        idle(2);
    endtask

    task automatic finishTest(string name);
        inValid = 1'b0; // the last uop was taken and must not be issued again.
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        idle(3);
        $display("%-16s %0d results, %0d errors", name, delivered - doneAtStart,
                 errors - errAtStart);
        doneAtStart = delivered;
        errAtStart = errors;
    endtask

    initial begin
        loadOp_t op;
        addr_t a;
        void'($urandom(33));
        en = 1'b0;
        stall = 1'b0;
        inValid = 1'b0;
        inOp = LB;
        inSrcA = '0;
        inSrcB = '0;
        inImm = '0;
        inPc = '0;
        inTagDst = '0;
        inSqN = '0;
        modeNoCregsRd = 1'b0;
        modeRmask = 1'b0;
        rmask = '1;
        branchTaken = 1'b0;
        branchSqN = '0;
        ramWrEn = 1'b0;
        ramWrAddr = '0;
        ramWrData = '0;
        @(negedge rst);
        @(negedge clk);
        for (int i = 0; i < RAM_WORDS; i++) begin
            memCopy[i] = $urandom();
            ramWrEn = 1'b1;
            ramWrAddr = addr_t'(i * 4);
            ramWrData = memCopy[i];
            @(negedge clk);
        end
        ramWrEn = 1'b0;
        running = 1'b1;

        repeat (N_ALIGNED) begin
            op = randomOp();
            issue(op, alignedAddr(op), 0);
        end
        finishTest("aligned loads");

        issue(LW, '0, 0);
        issue(AMOSWAP_W, 32'h0000_0100, 0);
        repeat (N_FAULT) begin
            op = loadOp_t'(4'($urandom_range(10)));
            a = ($urandom_range(5) == 0) ? '0 : $urandom();
            issue(op, a, 0);
        end
        finishTest("faults and swap");

        modeNoCregsRd = 1'b1;
        modeRmask = 1'b1;
        rmask = {$urandom(), $urandom()};
        for (int pass = 0; pass < 2; pass++) begin
            repeat (N_MODE) begin
                a = $urandom() & ~32'h3;
                if ($urandom_range(1) == 1) begin
                    a[31:24] = CREG_PAGE;
                end
                issue(($urandom_range(1) == 1) ? LW : LW_RR, (a == '0) ? 32'h4 : a, 0);
            end
            modeNoCregsRd = 1'b0;
            modeRmask = 1'b0;
        end
        finishTest("mode checks");

        repeat (N_STALL) begin
            op = randomOp();
            issue(op, alignedAddr(op), 30);
        end
        finishTest("random stalls");

        for (int r = 0; r < N_BRANCH; r++) begin
            branchRound(r % 4, r[2]);
        end
        finishTest("branch squash");

        en = 1'b0;
        inValid = 1'b1;
        repeat (8) @(negedge clk);
        idle(8);
        finishTest("idle cycles");

        $display("summary: %0d results checked, %0d errors", delivered, errors);
        if (errors == 0 && expQ.size() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (running);
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the loads did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- loadUnit.f
hdl/loadPkg.sv
hdl/loadAgu.sv
hdl/loadDataRam.sv
hdl/loadAligner.sv
hdl/loadUnit.sv
sim/clockGen.sv
sim/loadUnit_props.sv
sim/loadUnitTb.sv

//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := loadUnitTb
FLIST  := loadUnit.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || \
		(echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
